//--- files.f
hw/mul_pkg.sv
hw/mul_ctrl.sv
hw/mul_operand_prep.sv
hw/booth_accum.sv
hw/mul_result_sel.sv
hw/mul_unit.sv
test/tb_clkgen.sv
test/tb_mul_unit.sv

//--- Makefile
TOP := tb_mul_unit

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f files.f

run: build
	@out=$$(./obj_dir/V$(TOP) 2>&1); echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

lint:
	verilator --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir

//--- test/tb_mul_unit.sv
`timescale 1ns/1ps

module tb_mul_unit import mul_pkg::*; ();

	localparam int NUM_CORNER  = 16;
	localparam int NUM_RAND    = 40;
	localparam int TBL_LEN     = NUM_CORNER + NUM_RAND;
	localparam int MIN_LAT     = 2;
	localparam int MAX_LAT     = 35;
	localparam int WATCHDOG_NS = TBL_LEN * 40 * 20 + 1000;
	localparam logic [31:0] LFSR_SEED = 32'h457e_d754;

	logic     clk;
	logic     rst_n;
	logic     mul_valid;
	mul_req_t req;
	logic     busy;
	logic     done;
	xlen_t    result;

	mul_op_t     tbl_op[TBL_LEN];
	xlen_t       tbl_src1[TBL_LEN];
	xlen_t       tbl_src2[TBL_LEN];
	xlen_t       tbl_exp[TBL_LEN];
	logic        tbl_hold[TBL_LEN];  // mul_valid stays up into the next entry.
	int          tbl_fill;
	logic [31:0] lfsr_state;
	mul_op_t     op_list[5] = '{OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU, OP_MULW};

	tb_clkgen u_clkgen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	mul_unit DUT (
		.clk       (clk),
		.rst_n     (rst_n),
		.mul_valid (mul_valid),
		.req       (req),
		.busy      (busy),
		.done      (done),
		.result    (result)
	);

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'hd000_0001;
		return s >> 1;
	endfunction

	// one lfsr step per bit taken.
	task automatic rand_bits(input int n, output xlen_t v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[XLEN-2:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	// full 128-bit product of the extended sources.
	function automatic xlen_t ref_result(input mul_op_t op, input xlen_t a, input xlen_t b);
		logic [127:0] ea;
		logic [127:0] eb;
		logic [127:0] prod;
		ea = {{64{a[63]}}, a};
		eb = {{64{b[63]}}, b};
		case (op)
		OP_MULHSU: eb = {64'd0, b};
		OP_MULHU: begin
			ea = {64'd0, a};
			eb = {64'd0, b};
		end
		OP_MULW: begin
			ea = {{96{a[31]}}, a[31:0]};
			eb = {{96{b[31]}}, b[31:0]};
		end
		default: ea = ea;
		endcase
		prod = ea * eb;
		if (op == OP_MUL)
			return prod[63:0];
		if (op == OP_MULW)
			return {{32{prod[31]}}, prod[31:0]};
		return prod[127:64];
	endfunction

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1, "run aborted");
	endtask

	task automatic check_val(input string name, input xlen_t got, input xlen_t exp);
		if (got !== exp) begin
			$display("error: time %0t signal %s got %h expected %h", $time, name, got, exp);
			$display("TEST RESULT: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic add_entry(input mul_op_t op, input xlen_t a, input xlen_t b, input logic hold);
		tbl_op[tbl_fill]   = op;
		tbl_src1[tbl_fill] = a;
		tbl_src2[tbl_fill] = b;
		tbl_hold[tbl_fill] = hold;
		tbl_exp[tbl_fill]  = ref_result(op, a, b);
		tbl_fill++;
	endtask

	task automatic fill_table();
		xlen_t a;
		xlen_t b;
		xlen_t mode;
		xlen_t hbit;
		add_entry(OP_MUL,    64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000, 1'b0);
		add_entry(OP_MULH,   64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000, 1'b0);
		add_entry(OP_MULHU,  64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000, 1'b0);
		add_entry(OP_MULHSU, 64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000, 1'b0);
		add_entry(OP_MULH,   64'hffff_ffff_ffff_ffff, 64'hffff_ffff_ffff_ffff, 1'b0);
		add_entry(OP_MULHU,  64'hffff_ffff_ffff_ffff, 64'hffff_ffff_ffff_ffff, 1'b0);
		add_entry(OP_MULHSU, 64'hffff_ffff_ffff_ffff, 64'hffff_ffff_ffff_ffff, 1'b0);
		add_entry(OP_MULHSU, 64'h0000_0000_0000_0005, 64'hffff_ffff_ffff_ffff, 1'b1);
		add_entry(OP_MUL,    64'hffff_ffff_ffff_ffff, 64'hffff_ffff_ffff_ffff, 1'b0);
		add_entry(OP_MULH,   64'h0000_0000_0000_0000, 64'hffff_ffff_ffff_ffff, 1'b0);
		add_entry(OP_MULHU,  64'h1234_5678_9abc_def0, 64'h0000_0000_0000_0000, 1'b0);
		add_entry(OP_MULW,   64'hdead_beef_0000_0007, 64'h1234_5678_ffff_fffd, 1'b1);
		add_entry(OP_MULW,   64'h0000_0000_7fff_ffff, 64'hffff_ffff_0000_0002, 1'b1);
		add_entry(OP_MUL,    64'h1234_5678_9abc_def0, 64'h0000_0000_0000_0003, 1'b0);
		add_entry(OP_MULH,   64'h7fff_ffff_ffff_ffff, 64'hffff_ffff_ffff_fffe, 1'b1);
		add_entry(OP_MULHU,  64'haaaa_aaaa_aaaa_aaaa, 64'h5555_5555_5555_5555, 1'b0);
		for (int k = 0; k < NUM_RAND; k++) begin
			rand_bits(64, a);
			rand_bits(2, mode);
			rand_bits(8, b);
			if (mode == 64'd1)
				b = ~b;  // small negative multiplier.
			else if (mode > 64'd1)
				rand_bits(64, b);
			rand_bits(1, hbit);
			add_entry(op_list[k % 5], a, b, hbit[0] && (k != NUM_RAND - 1));
		end
	endtask

	task automatic run_entry(input int idx);
		int waited;
		@(posedge clk);
		#1;
		req.op    = tbl_op[idx];
		req.src1  = tbl_src1[idx];
		req.src2  = tbl_src2[idx];
		mul_valid = 1'b1;
		waited    = 0;
		@(negedge clk);
		while (done !== 1'b1) begin
			check_val("busy", xlen_t'(busy), 64'd1);
			waited++;
			if (waited - 1 > MAX_LAT)
				fail_run("done did not arrive within the allowed number of cycles");
			@(negedge clk);
		end
		if (waited - 1 < MIN_LAT)
			fail_run("done arrived sooner than the shortest possible latency");
		check_val("busy", xlen_t'(busy), 64'd0);
		check_val("result", result, tbl_exp[idx]);
		if (!tbl_hold[idx]) begin
			@(posedge clk);
			#1 mul_valid = 1'b0;
			repeat (3) begin
				@(negedge clk);
				check_val("busy", xlen_t'(busy), 64'd0);
				check_val("done", xlen_t'(done), 64'd0);
				check_val("result", result, tbl_exp[idx]);
			end
		end
	endtask

	initial begin
		#(WATCHDOG_NS);
		fail_run("watchdog expired before all table entries completed");
	end

	initial begin
		mul_valid  = 1'b0;
		req        = '0;
		tbl_fill   = 0;
		lfsr_state = LFSR_SEED;
		fill_table();
		@(posedge rst_n);
		repeat (2) @(posedge clk);
		@(negedge clk);
		check_val("busy", xlen_t'(busy), 64'd0);
		check_val("done", xlen_t'(done), 64'd0);
		check_val("result", result, 64'd0);
		for (int i = 0; i < TBL_LEN; i++)
			run_entry(i);
		@(posedge clk);
		#1 mul_valid = 1'b0;
		repeat (2) @(posedge clk);
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

//--- test/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
	output logic clk,
	output logic rst_n
);

	localparam int HALF_PERIOD = 10;  // 20 ns clock.
	localparam int RST_CYCLES  = 5;

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		#1 rst_n = 1'b1;
	end

endmodule

//--- hw/mul_unit.sv
`timescale 1ns/1ps

module mul_unit import mul_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     mul_valid,
	input  mul_req_t req,
	output logic     busy,
	output logic     done,
	output xlen_t    result
);

	logic          load;
	logic          step;
	logic          finish;
	logic          rem_trivial;
	mul_operands_t opnds;
	acc_t          acc;

	mul_ctrl u_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.mul_valid   (mul_valid),
		.rem_trivial (rem_trivial),
		.load        (load),
		.step        (step),
		.finish      (finish),
		.busy        (busy),
		.done        (done)
	);

	mul_operand_prep u_prep (
		.req   (req),
		.opnds (opnds)
	);

	booth_accum u_booth (
		.clk         (clk),
		.rst_n       (rst_n),
		.load        (load),
		.step        (step),
		.opnds       (opnds),
		.acc         (acc),
		.rem_trivial (rem_trivial)
	);

	// op is sampled on load, req is still held then.
	mul_result_sel u_res (
		.clk    (clk),
		.rst_n  (rst_n),
		.load   (load),
		.finish (finish),
		.op     (req.op),
		.acc    (acc),
		.result (result)
	);

endmodule

//--- hw/mul_result_sel.sv
`timescale 1ns/1ps

module mul_result_sel import mul_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    load,
	input  logic    finish,
	input  mul_op_t op,
	input  acc_t    acc,
	output xlen_t   result
);

	mul_op_t op_q;
	xlen_t   res_lo;
	xlen_t   res_hi;
	xlen_t   res_word;
	xlen_t   res_sel;

	assign res_lo   = acc[XLEN-1:0];
	assign res_hi   = acc[2*XLEN-1:XLEN];
	assign res_word = {{(XLEN-32){acc[31]}}, acc[31:0]};

	always_comb begin
		case (op_q)
		OP_MUL: begin
			res_sel = res_lo;
		end
		OP_MULH, OP_MULHSU, OP_MULHU: begin
			res_sel = res_hi;
		end
		OP_MULW: begin
			res_sel = res_word;
		end
		default: begin
			res_sel = res_lo;
		end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			op_q   <= OP_MUL;
			result <= '0;
		end else begin
			if (load)
				op_q <= op;
			if (finish)
				result <= res_sel;  // held until the next finish.
		end
	end

endmodule

//--- hw/booth_accum.sv
`timescale 1ns/1ps

module booth_accum import mul_pkg::*; (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          load,
	input  logic          step,
	input  mul_operands_t opnds,
	output acc_t          acc,
	output logic          rem_trivial
);

	acc_t           mcand_q;
	logic [EXT_W:0] mplier_q;  // multiplier with the pending low bit below it.
	booth_grp_t     grp;
	acc_t           mcand_x2;
	acc_t           pp_mag;
	logic           pp_neg;
	acc_t           acc_nxt;

	assign grp      = mplier_q[2:0];
	assign mcand_x2 = mcand_q << 1;

	// radix-4 recoding.
	always_comb begin
		pp_mag = '0;
		pp_neg = 1'b0;
		case (grp)
		3'b001, 3'b010: begin
			pp_mag = mcand_q;
		end
		3'b011: begin
			pp_mag = mcand_x2;
		end
		3'b100: begin
			pp_mag = mcand_x2;
			pp_neg = 1'b1;
		end
		3'b101, 3'b110: begin
			pp_mag = mcand_q;
			pp_neg = 1'b1;
		end
		default: begin
			pp_mag = '0;
			pp_neg = 1'b0;
		end
		endcase
	end

	// subtract as invert plus carry in.
	assign acc_nxt = acc + (pp_mag ^ {ACC_W{pp_neg}}) + acc_t'(pp_neg);

	// all ones or all zeros left, nothing more to add.
	assign rem_trivial = (&mplier_q) | ~(|mplier_q);

	always_ff @(posedge clk) begin
		if (load) begin
			mcand_q <= {{(ACC_W-EXT_W){opnds.mcand[EXT_W-1]}}, opnds.mcand};
		end else if (step) begin
			mcand_q <= mcand_q << 2;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mplier_q <= '0;
			acc      <= '0;
		end else if (load) begin
			mplier_q <= {opnds.mplier, 1'b0};
			acc      <= '0;
		end else if (step) begin
			mplier_q <= {{2{mplier_q[EXT_W]}}, mplier_q[EXT_W:2]};  // arithmetic shift.
			acc      <= acc_nxt;
		end
	end

	a_load_step_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(load && step));

endmodule

//--- hw/mul_operand_prep.sv
`timescale 1ns/1ps

module mul_operand_prep import mul_pkg::*; (
	input  mul_req_t      req,
	output mul_operands_t opnds
);

	logic  src1_signed;
	logic  src2_signed;
	logic  word_mode;
	xlen_t src1_w;
	xlen_t src2_w;

	// low half of MUL is the same either way, keep it signed.
	always_comb begin
		src1_signed = 1'b1;
		src2_signed = 1'b1;
		word_mode   = 1'b0;
		case (req.op)
		OP_MULHSU: begin
			src2_signed = 1'b0;
		end
		OP_MULHU: begin
			src1_signed = 1'b0;
			src2_signed = 1'b0;
		end
		OP_MULW: begin
			word_mode = 1'b1;
		end
		default: begin
			word_mode = 1'b0;
		end
		endcase
	end

	// word mode works on the low 32 bits only.
	assign src1_w = word_mode ? {{(XLEN-32){req.src1[31]}}, req.src1[31:0]} : req.src1;
	assign src2_w = word_mode ? {{(XLEN-32){req.src2[31]}}, req.src2[31:0]} : req.src2;

	assign opnds.mcand  = {{(EXT_W-XLEN){src1_signed & src1_w[XLEN-1]}}, src1_w};
	assign opnds.mplier = {{(EXT_W-XLEN){src2_signed & src2_w[XLEN-1]}}, src2_w};

endmodule

//--- hw/mul_ctrl.sv
`timescale 1ns/1ps

module mul_ctrl import mul_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic mul_valid,
	input  logic rem_trivial,
	output logic load,
	output logic step,
	output logic finish,
	output logic busy,
	output logic done
);

	mul_state_t state;
	mul_state_t state_nxt;
	step_cnt_t  step_cnt;
	logic       last_step;

	// the request is still up in the done cycle, so it must not reload.
	assign load   = (state == ST_IDLE) && mul_valid && !done;
	assign step   = (state == ST_RUN);
	assign finish = (state == ST_FINISH);
	assign busy   = mul_valid && !done;

	// remaining groups add nothing, or the last group is being consumed.
	assign last_step = rem_trivial || (step_cnt == step_cnt_t'(BOOTH_STEPS - 1));

	always_comb begin
		state_nxt = state;
		case (state)
		ST_IDLE: begin
			if (load)
				state_nxt = ST_RUN;
		end
		ST_RUN: begin
			if (last_step)
				state_nxt = ST_FINISH;
		end
		ST_FINISH: begin
			state_nxt = ST_IDLE;
		end
		default: begin
			state_nxt = ST_IDLE;
		end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			step_cnt <= '0;
		end else if (load) begin
			step_cnt <= '0;
		end else if (step) begin
			step_cnt <= step_cnt + step_cnt_t'(1);
		end
	end

	// registered so it lines up with the result register.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			done <= 1'b0;
		end else begin
			done <= finish;
		end
	end

	a_step_cnt_bound: assert property (@(posedge clk) disable iff (!rst_n)
		step_cnt <= step_cnt_t'(BOOTH_STEPS));

	a_done_single: assert property (@(posedge clk) disable iff (!rst_n)
		done |=> !done);

endmodule

//--- hw/mul_pkg.sv
package mul_pkg;

	localparam int XLEN        = 64;
	localparam int EXT_W       = 66;  // one spare bit for sign, one for booth pairing.
	localparam int ACC_W       = 130;
	localparam int BOOTH_STEPS = 33;  // EXT_W / 2 groups.
	localparam int STEP_CNT_W  = 6;

	typedef logic [XLEN-1:0]       xlen_t;
	typedef logic [EXT_W-1:0]      ext_t;
	typedef logic [ACC_W-1:0]      acc_t;
	typedef logic [2:0]            booth_grp_t;
	typedef logic [STEP_CNT_W-1:0] step_cnt_t;

	typedef enum logic [2:0] {
		OP_MUL    = 3'd0,
		OP_MULH   = 3'd1,
		OP_MULHSU = 3'd2,
		OP_MULHU  = 3'd3,
		OP_MULW   = 3'd4
	} mul_op_t;

	typedef enum logic [1:0] {
		ST_IDLE   = 2'd0,
		ST_RUN    = 2'd1,
		ST_FINISH = 2'd2
	} mul_state_t;

	// request as held by the issue stage.
	typedef struct packed {
		mul_op_t op;
		xlen_t   src1;
		xlen_t   src2;
	} mul_req_t;

	// extended operands into the booth core.
	typedef struct packed {
		ext_t mcand;
		ext_t mplier;
	} mul_operands_t;

endpackage
